// ==== src.f ====
hw/dmr_pkg.sv
hw/dmr_regs.sv
hw/dmr_mode_fsm.sv
hw/dmr_checker.sv
hw/dmr_top.sv
sim/dmr_tb.sv

// ==== Bender.yml ====
package:
  name: dmr_ctrl

sources:
  - hw/dmr_pkg.sv
  - hw/dmr_regs.sv
  - hw/dmr_mode_fsm.sv
  - hw/dmr_checker.sv
  - hw/dmr_top.sv
  - target: simulation
    files:
      - sim/dmr_tb.sv

// ==== sim/dmr_tb.sv ====
// Testbench for dmr_top with RapidRecovery set; replicas and restore engine are modeled here
`default_nettype none
`timescale 1ns/10ps

module dmr_tb;

  import dmr_pkg::*;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned CntWidth  = 8;
  localparam int          MaxCycles = 2000;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic [RegAddrWidth-1:0] reg_addr_i;
  logic                    reg_wr_i;
  logic [RegDataWidth-1:0] reg_wdata_i;
  logic [RegDataWidth-1:0] reg_rdata_o;
  logic                    core_valid_i;
  logic [DataWidth-1:0]    core_a_data_i;
  logic [DataWidth-1:0]    core_b_data_i;
  logic                    fetch_en_i;
  logic                    cores_synch_i;
  logic                    recovery_finished_i;
  logic [1:0]              setback_o;
  logic                    sw_synch_req_o;
  logic                    sw_resynch_req_o;
  logic                    recovery_request_o;
  logic                    grp_in_independent_o;
  logic                    rapid_recovery_en_o;

  // Expected group state as the stimulus knows it
  logic                    lock_chk;
  logic                    rapid_chk;
  logic                    pair_diff;
  integer                  seed = 32'h8aa0_cbcf;
  int                      cycle_cnt = 0;
  int                      diff_cnt;
  logic [RegDataWidth-1:0] rdata;

  dmr_top #(
    .DMRFixed     (1'b0),
    .RapidRecovery(1'b1),
    .DataWidth    (DataWidth),
    .CntWidth     (CntWidth)
  ) dmr_top_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .reg_addr_i          (reg_addr_i),
    .reg_wr_i            (reg_wr_i),
    .reg_wdata_i         (reg_wdata_i),
    .reg_rdata_o         (reg_rdata_o),
    .core_valid_i        (core_valid_i),
    .core_a_data_i       (core_a_data_i),
    .core_b_data_i       (core_b_data_i),
    .fetch_en_i          (fetch_en_i),
    .cores_synch_i       (cores_synch_i),
    .recovery_finished_i (recovery_finished_i),
    .setback_o           (setback_o),
    .sw_synch_req_o      (sw_synch_req_o),
    .sw_resynch_req_o    (sw_resynch_req_o),
    .recovery_request_o  (recovery_request_o),
    .grp_in_independent_o(grp_in_independent_o),
    .rapid_recovery_en_o (rapid_recovery_en_o)
  );

  always #5 clk_i = ~clk_i;

  assign pair_diff = core_valid_i && (core_a_data_i != core_b_data_i);

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else
      report_failure($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h",
                               name, expected, actual));
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MaxCycles) begin
      report_failure("Timeout: the test sequence did not finish within the cycle limit");
    end
  end

  // One resync pulse per differing pair in lockstep without rapid recovery, and none otherwise
  resync_on_mismatch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lock_chk && !rapid_chk && pair_diff) |=> sw_resynch_req_o
  ) else report_failure("Error: no resync request after a mismatch in lockstep");
  no_spurious_resync: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(lock_chk && !rapid_chk && pair_diff) |=> !sw_resynch_req_o
  ) else report_failure("Error: resync request without a lockstep mismatch");
  restore_on_mismatch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lock_chk && rapid_chk && pair_diff) |=> ##1 recovery_request_o
  ) else report_failure("Error: rapid recovery did not start after a mismatch");
  restore_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (recovery_request_o && !recovery_finished_i) |=> recovery_request_o
  ) else report_failure("Error: recovery request dropped before recovery finished");
  restore_ends: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (recovery_request_o && recovery_finished_i) |=> !recovery_request_o
  ) else report_failure("Error: recovery request still high after recovery finished");
  synch_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sw_synch_req_o && !cores_synch_i) |=> sw_synch_req_o
  ) else report_failure("Error: synch request dropped before the cores synchronized");
  synch_lock: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sw_synch_req_o && cores_synch_i) |=> (setback_o == 2'b11 && !grp_in_independent_o)
  ) else report_failure("Error: no lockstep setback after the cores synchronized");
  release_setback: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (setback_o == 2'b10) |-> (grp_in_independent_o ##1 (setback_o == 2'b00))
  ) else report_failure("Error: release setback was not a single independent cycle");

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic write_reg(input dmr_reg_e addr, input logic [31:0] data);
    reg_addr_i  = addr;
    reg_wdata_i = data;
    reg_wr_i    = 1'b1;
    step();
    reg_wr_i    = 1'b0;
  endtask

  task automatic read_reg(input dmr_reg_e addr, output logic [31:0] data);
    reg_addr_i = addr;
    #2;
    data = reg_rdata_o;
    step();
  endtask

  // One valid beat followed by an idle cycle, so errors never come back to back
  task automatic drive_pair(input bit differ);
    logic [DataWidth-1:0] flip;
    flip          = differ ? (32'h1 << ($random(seed) & 31)) : '0;
    core_valid_i  = 1'b1;
    core_a_data_i = $random(seed);
    core_b_data_i = core_a_data_i ^ flip;
    step();
    core_valid_i  = 1'b0;
    step();
  endtask

  // Restore engine model with a random latency
  task automatic run_recovery();
    lock_chk = 1'b0;
    while (!recovery_request_o) step();
    repeat (($random(seed) & 7) + 2) step();
    recovery_finished_i = 1'b1;
    step();
    recovery_finished_i = 1'b0;
    check_value("recovery release", 0, recovery_request_o);
    lock_chk = 1'b1;
  endtask

  initial begin
    bit differ;
    rst_ni = 1'b0;
    reg_addr_i = '0;
    reg_wr_i = 1'b0;
    reg_wdata_i = '0;
    core_valid_i = 1'b0;
    core_a_data_i = '0;
    core_b_data_i = '0;
    fetch_en_i = 1'b0;
    cores_synch_i = 1'b0;
    recovery_finished_i = 1'b0;
    lock_chk = 1'b0;
    rapid_chk = 1'b0;
    diff_cnt = 0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fetch_en_i = 1'b1;
    step();

    write_reg(REG_CONFIG, 32'h1);
    read_reg(REG_CONFIG, rdata);
    check_value("config readback", 32'h1, rdata);
    check_value("rapid enable", 1, rapid_recovery_en_o);
    write_reg(REG_CONFIG, 32'h0);
    read_reg(REG_CONFIG, rdata);
    check_value("config clear", 32'h0, rdata);
    check_value("rapid disable", 0, rapid_recovery_en_o);

    // Enable lockstep and let the synch request wait a few cycles
    write_reg(REG_ENABLE, 32'h1);
    read_reg(REG_ENABLE, rdata);
    check_value("enable readback", 32'h1, rdata);
    repeat (4) step();
    check_value("synch request", 1, sw_synch_req_o);
    cores_synch_i = 1'b1;
    step();
    cores_synch_i = 1'b0;
    check_value("lock setback", 2'b11, setback_o);
    check_value("lock independent", 0, grp_in_independent_o);
    lock_chk = 1'b1;

    for (int i = 0; i < 40; i++) begin
      differ = (i == 0) || (($random(seed) & 3) == 0);
      if (differ) diff_cnt++;
      drive_pair(differ);
    end
    read_reg(REG_MISMATCH, rdata);
    check_value("mismatch count", diff_cnt, rdata);
    write_reg(REG_MISMATCH, 32'h0);
    read_reg(REG_MISMATCH, rdata);
    check_value("counter clear", 32'h0, rdata);
    diff_cnt = 0;

    write_reg(REG_CONFIG, 32'h1);
    rapid_chk = 1'b1;
    drive_pair(1'b1);
    diff_cnt++;
    run_recovery();
    write_reg(REG_CONFIG, 32'h3);
    run_recovery();
    read_reg(REG_CONFIG, rdata);
    check_value("force self-clear", 32'h1, rdata);

    write_reg(REG_CONFIG, 32'h0);
    rapid_chk = 1'b0;
    lock_chk = 1'b0;
    write_reg(REG_ENABLE, 32'h0);
    step();
    check_value("release setback", 2'b10, setback_o);
    check_value("release independent", 1, grp_in_independent_o);
    repeat (10) drive_pair(1'b1);
    read_reg(REG_MISMATCH, rdata);
    check_value("independent count", diff_cnt, rdata);

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/dmr_top.sv ====
// DMR control slice top; cores and state-restore engine sit outside and drive the group inputs
`default_nettype none
`timescale 1ns/10ps

module dmr_top #(
  parameter bit          DMRFixed      = 1'b0,
  parameter bit          RapidRecovery = 1'b0,
  parameter int unsigned DataWidth     = 32,
  parameter int unsigned CntWidth      = 8
) (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  input  wire logic [dmr_pkg::RegAddrWidth-1:0] reg_addr_i,
  input  wire logic                             reg_wr_i,
  input  wire logic [dmr_pkg::RegDataWidth-1:0] reg_wdata_i,
  output logic      [dmr_pkg::RegDataWidth-1:0] reg_rdata_o,
  input  wire logic                             core_valid_i,
  input  wire logic [DataWidth-1:0]             core_a_data_i,
  input  wire logic [DataWidth-1:0]             core_b_data_i,
  input  wire logic                             fetch_en_i,
  input  wire logic                             cores_synch_i,
  input  wire logic                             recovery_finished_i,
  output logic      [1:0]                       setback_o,
  output logic                                  sw_synch_req_o,
  output logic                                  sw_resynch_req_o,
  output logic                                  recovery_request_o,
  output logic                                  grp_in_independent_o,
  output logic                                  rapid_recovery_en_o
);

  logic                dmr_enable;
  logic                rapid_recovery_cfg;
  logic                force_recovery;
  logic                force_clr;
  logic                cnt_clr;
  logic [CntWidth-1:0] mismatch_cnt;
  logic                lockstep;
  logic                dmr_error;

  dmr_regs #(
    .RapidRecovery(RapidRecovery),
    .CntWidth     (CntWidth)
  ) dmr_regs_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .reg_addr_i      (reg_addr_i),
    .reg_wr_i        (reg_wr_i),
    .reg_wdata_i     (reg_wdata_i),
    .reg_rdata_o     (reg_rdata_o),
    .force_clr_i     (force_clr),
    .mismatch_cnt_i  (mismatch_cnt),
    .dmr_enable_o    (dmr_enable),
    .rapid_recovery_o(rapid_recovery_cfg),
    .force_recovery_o(force_recovery),
    .cnt_clr_o       (cnt_clr)
  );

  dmr_mode_fsm #(
    .DMRFixed     (DMRFixed),
    .RapidRecovery(RapidRecovery)
  ) dmr_mode_fsm_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .dmr_enable_i        (dmr_enable),
    .rapid_recovery_i    (rapid_recovery_cfg),
    .force_recovery_i    (force_recovery),
    .dmr_error_i         (dmr_error),
    .fetch_en_i          (fetch_en_i),
    .cores_synch_i       (cores_synch_i),
    .recovery_finished_i (recovery_finished_i),
    .force_clr_o         (force_clr),
    .lockstep_o          (lockstep),
    .setback_o           (setback_o),
    .sw_synch_req_o      (sw_synch_req_o),
    .sw_resynch_req_o    (sw_resynch_req_o),
    .recovery_request_o  (recovery_request_o),
    .grp_in_independent_o(grp_in_independent_o),
    .rapid_recovery_en_o (rapid_recovery_en_o)
  );

  dmr_checker #(
    .DataWidth(DataWidth),
    .CntWidth (CntWidth)
  ) dmr_checker_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lockstep_i    (lockstep),
    .core_valid_i  (core_valid_i),
    .core_a_data_i (core_a_data_i),
    .core_b_data_i (core_b_data_i),
    .cnt_clr_i     (cnt_clr),
    .dmr_error_o   (dmr_error),
    .mismatch_cnt_o(mismatch_cnt)
  );

endmodule

`default_nettype wire

// ==== hw/dmr_checker.sv ====
// DMR output checker; compares only in lockstep, error lags the compare by one cycle
`default_nettype none
`timescale 1ns/10ps

module dmr_checker #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned CntWidth  = 8
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 lockstep_i,
  input  wire logic                 core_valid_i,
  input  wire logic [DataWidth-1:0] core_a_data_i,
  input  wire logic [DataWidth-1:0] core_b_data_i,
  input  wire logic                 cnt_clr_i,
  output logic                      dmr_error_o,
  output logic      [CntWidth-1:0]  mismatch_cnt_o
);

  logic                mismatch;
  logic                error_q;
  logic [CntWidth-1:0] cnt_q;
  logic                cnt_full;

  assign mismatch = lockstep_i && core_valid_i && (core_a_data_i != core_b_data_i);
  assign cnt_full = &cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      error_q <= 1'b0;
    end else begin
      error_q <= mismatch;
    end
  end

  // Saturating counter, a software clear beats a same-cycle mismatch
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_clr_i) begin
      cnt_q <= '0;
    end else if (mismatch && !cnt_full) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign dmr_error_o    = error_q;
  assign mismatch_cnt_o = cnt_q;

  // Replicas are not expected to disagree on two back-to-back valid beats
  a_error_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dmr_error_o |=> !dmr_error_o
  );

endmodule

`default_nettype wire

// ==== hw/dmr_mode_fsm.sv ====
// DMR mode FSM; setback pulses are one cycle, enable changes only act when DMRFixed is clear
`default_nettype none
`timescale 1ns/10ps

module dmr_mode_fsm #(
  parameter bit DMRFixed      = 1'b0,
  parameter bit RapidRecovery = 1'b0
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       dmr_enable_i,
  input  wire logic       rapid_recovery_i,
  input  wire logic       force_recovery_i,
  input  wire logic       dmr_error_i,
  input  wire logic       fetch_en_i,
  input  wire logic       cores_synch_i,
  input  wire logic       recovery_finished_i,
  output logic            force_clr_o,
  output logic            lockstep_o,
  output logic      [1:0] setback_o,
  output logic            sw_synch_req_o,
  output logic            sw_resynch_req_o,
  output logic            recovery_request_o,
  output logic            grp_in_independent_o,
  output logic            rapid_recovery_en_o
);

  import dmr_pkg::*;

  localparam dmr_mode_e ResetMode = DMRFixed ? DMR_RUN : NON_DMR;

  dmr_mode_e  mode_q;
  dmr_mode_e  mode_d;
  logic [1:0] setback_q;
  logic [1:0] setback_d;
  logic       rapid_en;

  assign rapid_en = rapid_recovery_i && RapidRecovery;

  always_comb begin
    mode_d             = mode_q;
    setback_d          = 2'b00;
    force_clr_o        = 1'b0;
    sw_synch_req_o     = 1'b0;
    sw_resynch_req_o   = 1'b0;
    recovery_request_o = 1'b0;

    case (mode_q)
      DMR_RUN: begin
        // Software-forced recovery consumes the force bit
        if (force_recovery_i && rapid_en) begin
          force_clr_o = 1'b1;
          mode_d      = DMR_RESTORE;
        end
        if (dmr_error_i) begin
          if (rapid_en) begin
            mode_d = DMR_RESTORE;
          end else begin
            sw_resynch_req_o = 1'b1;
          end
        end
      end
      DMR_RESTORE: begin
        recovery_request_o = 1'b1;
        if (recovery_finished_i) begin
          mode_d = DMR_RUN;
        end
      end
      default: begin
        mode_d = mode_q;
      end
    endcase

    if (!DMRFixed) begin
      // Mode tracks the enable bit while the cores are not fetching
      if (!fetch_en_i) begin
        mode_d = dmr_enable_i ? DMR_RUN : NON_DMR;
      end
      // Split back into independent cores
      if (mode_q == DMR_RUN && !dmr_enable_i) begin
        mode_d    = NON_DMR;
        setback_d = 2'b10;
      end
      // Ask software to synchronize and lock once the cores report it
      if (mode_q == NON_DMR && dmr_enable_i && fetch_en_i) begin
        sw_synch_req_o = 1'b1;
        if (cores_synch_i) begin
          mode_d    = DMR_RUN;
          setback_d = 2'b11;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q    <= ResetMode;
      setback_q <= 2'b00;
    end else begin
      mode_q    <= mode_d;
      setback_q <= setback_d;
    end
  end

  assign setback_o            = setback_q;
  assign lockstep_o           = (mode_q == DMR_RUN);
  assign grp_in_independent_o = (mode_q == NON_DMR);
  assign rapid_recovery_en_o  = rapid_en;

  a_setback_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (setback_o != 2'b00) |=> (setback_o == 2'b00)
  );

  // Restore is only entered from a locked group
  a_no_recovery_independent: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    recovery_request_o |-> !$past(grp_in_independent_o)
  );

endmodule

`default_nettype wire

// ==== hw/dmr_regs.sv ====
// DMR register block; single-cycle write strobe, combinational read, unmapped offsets read 0
`default_nettype none
`timescale 1ns/10ps

module dmr_regs #(
  parameter bit          RapidRecovery = 1'b0,
  parameter int unsigned CntWidth      = 8
) (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic [dmr_pkg::RegAddrWidth-1:0] reg_addr_i,
  input  wire logic                            reg_wr_i,
  input  wire logic [dmr_pkg::RegDataWidth-1:0] reg_wdata_i,
  output logic      [dmr_pkg::RegDataWidth-1:0] reg_rdata_o,
  input  wire logic                            force_clr_i,
  input  wire logic [CntWidth-1:0]             mismatch_cnt_i,
  output logic                                 dmr_enable_o,
  output logic                                 rapid_recovery_o,
  output logic                                 force_recovery_o,
  output logic                                 cnt_clr_o
);

  import dmr_pkg::*;

  dmr_reg_e reg_sel;
  logic     enable_q;
  logic     rapid_q;
  logic     force_q;
  logic     wr_enable;
  logic     wr_config;

  assign reg_sel   = dmr_reg_e'(reg_addr_i);
  assign wr_enable = reg_wr_i && (reg_sel == REG_ENABLE);
  assign wr_config = reg_wr_i && (reg_sel == REG_CONFIG);

  // Counter clear goes out with the write strobe itself
  assign cnt_clr_o = reg_wr_i && (reg_sel == REG_MISMATCH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= 1'b0;
      rapid_q  <= 1'b0;
      force_q  <= 1'b0;
    end else begin
      if (wr_enable) begin
        enable_q <= reg_wdata_i[0];
      end
      if (wr_config) begin
        // Rapid recovery sticks at 0 without hardware support
        rapid_q <= reg_wdata_i[0] && RapidRecovery;
        force_q <= reg_wdata_i[1];
      end else if (force_clr_i) begin
        // Self-clearing once the FSM has taken the request
        force_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_sel)
      REG_ENABLE: begin
        reg_rdata_o[0] = enable_q;
      end
      REG_CONFIG: begin
        reg_rdata_o[0] = rapid_q;
        reg_rdata_o[1] = force_q;
      end
      REG_MISMATCH: begin
        reg_rdata_o = RegDataWidth'(mismatch_cnt_i);
      end
      default: begin
        reg_rdata_o = '0;
      end
    endcase
  end

  assign dmr_enable_o     = enable_q;
  assign rapid_recovery_o = rapid_q;
  assign force_recovery_o = force_q;

  // The FSM only acknowledges a force request that is actually pending
  a_force_clr_pending: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(force_clr_i) |-> force_recovery_o
  );

endmodule

`default_nettype wire

// ==== hw/dmr_pkg.sv ====
// Shared DMR definitions; register offsets are byte addresses on a 4-bit word-aligned space
`default_nettype none

package dmr_pkg;

  // Register bus geometry
  localparam int unsigned RegAddrWidth = 4;
  localparam int unsigned RegDataWidth = 32;

  // Redundancy mode of the core group
  typedef enum logic [1:0] {
    NON_DMR     = 2'd0,
    DMR_RUN     = 2'd1,
    DMR_RESTORE = 2'd2
  } dmr_mode_e;

  // Byte offsets of the software-visible registers
  // REG_CONFIG holds rapid_recovery in bit 0 and force_recovery in bit 1
  typedef enum logic [RegAddrWidth-1:0] {
    REG_ENABLE   = 4'd0,
    REG_CONFIG   = 4'd4,
    REG_MISMATCH = 4'd8
  } dmr_reg_e;

endpackage

`default_nettype wire
